// ==== src/ahb_mem_pkg.sv ====
`default_nettype none

package ahb_mem_pkg;

    // --------------------
    // Bus vectors
    // --------------------
    typedef logic [31:0] haddr_t;   // Byte address.
    typedef logic [31:0] hdata_t;   // Read or write word.
    typedef logic [1:0]  htrans_t;
    typedef logic [2:0]  hburst_t;  // Bit 0 set for incrementing bursts.

    // --------------------
    // Transfer types
    // --------------------
    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_BUSY   = 2'b01;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam htrans_t HTRANS_SEQ    = 2'b11;

    // --------------------
    // Controller
    // --------------------
    typedef logic [3:0] wait_cnt_t;  // Up to 15 wait states.

    typedef enum logic [2:0] {
        XFER_IDLE,    // No data phase.
        XFER_WAIT,    // Wait states counting.
        XFER_ACCESS,  // Completing cycle.
        XFER_ERR1,    // Error, hready low.
        XFER_ERR2     // Error, hready high.
    } xfer_state_t;

endpackage

`default_nettype wire

// ==== src/mem_port_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// One memory access per cycle from the controller to the array.
interface mem_port_if #(
    parameter int MEM_WORDS = 1024
);

    localparam int WORD_W = $clog2(MEM_WORDS);

    logic                en;     // Access strobe.
    logic                we;     // Write when set.
    logic [WORD_W-1:0]   word;   // Word index.
    ahb_mem_pkg::hdata_t wdata;
    ahb_mem_pkg::hdata_t rdata;  // Valid the cycle after a read.

    modport ctrl (
        output en,
        output we,
        output word,
        output wdata,
        input  rdata
    );

    modport mem (
        input  en,
        input  we,
        input  word,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== src/ahb_addr_phase.sv ====
`timescale 1ns/1ns
`default_nettype none

module ahb_addr_phase #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                            mem_intf,
    input  logic                            rst_n,
    input  ahb_mem_pkg::haddr_t             haddr,
    input  ahb_mem_pkg::htrans_t            htrans,
    input  logic                            hwrite,
    input  ahb_mem_pkg::hburst_t            hburst,
    input  logic                            hready,
    output logic                            phase_valid,
    output logic                            phase_write,
    output logic                            phase_err,
    output logic [$clog2(MEM_WORDS)-1:0]    phase_word
);

    localparam int WORD_W = $clog2(MEM_WORDS);
    localparam ahb_mem_pkg::haddr_t MEM_BYTES = ahb_mem_pkg::haddr_t'(MEM_WORDS * 4);

    logic                 addr_valid;
    ahb_mem_pkg::haddr_t  prev_addr;
    ahb_mem_pkg::hburst_t prev_burst;
    ahb_mem_pkg::htrans_t prev_trans;

    assign addr_valid = (htrans == ahb_mem_pkg::HTRANS_NONSEQ) ||
                        (htrans == ahb_mem_pkg::HTRANS_SEQ);

    // --------------------
    // Held address phase
    // --------------------
    always_ff @(posedge mem_intf) begin
        if (!rst_n) begin
            phase_valid <= 1'b0;
            phase_write <= 1'b0;
            phase_err   <= 1'b0;
            prev_trans  <= ahb_mem_pkg::HTRANS_IDLE;
        end else if (hready) begin
            phase_valid <= addr_valid;               // IDLE and BUSY drop out here.
            phase_write <= hwrite;
            phase_err   <= addr_valid && (haddr >= MEM_BYTES);
            prev_trans  <= htrans;
        end
    end

    always_ff @(posedge mem_intf) begin
        if (hready) begin
            phase_word <= haddr[WORD_W+1:2];         // Byte lanes ignored.
        end
        if (hready && addr_valid) begin
            prev_addr  <= haddr;                     // Last real beat only.
            prev_burst <= hburst;
        end
    end

    // --------------------
    // Burst checks
    // --------------------
    // Incrementing bursts step one word per beat; wrapping bursts are not checked.
    a_seq_incr: assert property (@(posedge mem_intf) disable iff (!rst_n)
        (hready && htrans == ahb_mem_pkg::HTRANS_SEQ && prev_burst[0])
            |-> (haddr == prev_addr + 32'd4))
        else $error("SEQ beat does not follow previous address");

    a_seq_after_idle: assert property (@(posedge mem_intf) disable iff (!rst_n)
        (hready && htrans == ahb_mem_pkg::HTRANS_SEQ)
            |-> (prev_trans != ahb_mem_pkg::HTRANS_IDLE))
        else $error("SEQ transfer after IDLE");

endmodule

`default_nettype wire

// ==== src/wait_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module wait_timer (
    input  logic                   mem_intf,
    input  logic                   rst_n,
    input  logic                   load,
    input  ahb_mem_pkg::wait_cnt_t load_val,
    output logic                   done
);

    ahb_mem_pkg::wait_cnt_t cnt;

    // --------------------
    // Down-counter
    // --------------------
    always_ff @(posedge mem_intf) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= load_val;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;                   // Parks at zero.
        end
    end

    assign done = (cnt == '0);

    // A reload while counting would cut a data phase short.
    a_load_idle: assert property (@(posedge mem_intf) disable iff (!rst_n)
        load |-> (cnt == '0))
        else $error("Timer loaded while still counting");

endmodule

`default_nettype wire

// ==== src/xfer_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module xfer_ctrl #(
    parameter int MEM_WORDS  = 1024,
    parameter int READ_WAIT  = 2,
    parameter int WRITE_WAIT = 1
) (
    input  logic                            mem_intf,
    input  logic                            rst_n,
    input  logic                            phase_valid,
    input  logic                            phase_write,
    input  logic                            phase_err,
    input  logic [$clog2(MEM_WORDS)-1:0]    phase_word,
    input  ahb_mem_pkg::hdata_t             hwdata,
    input  logic                            done,
    output logic                            hready,
    output logic                            hresp,
    output logic                            load,
    output ahb_mem_pkg::wait_cnt_t          load_val,
    mem_port_if.ctrl                        mem
);

    localparam ahb_mem_pkg::wait_cnt_t READ_W  = ahb_mem_pkg::wait_cnt_t'(READ_WAIT);
    localparam ahb_mem_pkg::wait_cnt_t WRITE_W = ahb_mem_pkg::wait_cnt_t'(WRITE_WAIT);

    ahb_mem_pkg::xfer_state_t state;
    ahb_mem_pkg::xfer_state_t cur_state;
    ahb_mem_pkg::xfer_state_t next_state;
    ahb_mem_pkg::wait_cnt_t   wait_sel;
    logic                     entry;
    logic                     last_wait;

    assign entry    = (state == ahb_mem_pkg::XFER_IDLE);
    assign wait_sel = phase_write ? WRITE_W : READ_W;

    // --------------------
    // Phase decode
    // --------------------
    // The first cycle of a data phase is decided from the held address phase.
    always_comb begin
        cur_state = state;
        if (entry && phase_valid) begin
            if (phase_err) begin
                cur_state = ahb_mem_pkg::XFER_ERR1;
            end else if (wait_sel == '0) begin
                cur_state = ahb_mem_pkg::XFER_ACCESS;  // Zero-wait write.
            end else begin
                cur_state = ahb_mem_pkg::XFER_WAIT;
            end
        end
    end

    // Timer only covers wait cycles after the first one.
    assign last_wait = (cur_state == ahb_mem_pkg::XFER_WAIT) &&
                       (entry ? (wait_sel == 4'd1) : done);

    assign load     = entry && (cur_state == ahb_mem_pkg::XFER_WAIT) && (wait_sel > 4'd1);
    assign load_val = wait_sel - 4'd2;

    always_comb begin
        case (cur_state)
            ahb_mem_pkg::XFER_WAIT: begin
                next_state = last_wait ? ahb_mem_pkg::XFER_ACCESS : ahb_mem_pkg::XFER_WAIT;
            end
            ahb_mem_pkg::XFER_ERR1: begin
                next_state = ahb_mem_pkg::XFER_ERR2;
            end
            default: begin
                next_state = ahb_mem_pkg::XFER_IDLE;   // Phase done or none.
            end
        endcase
    end

    always_ff @(posedge mem_intf) begin
        if (!rst_n) begin
            state <= ahb_mem_pkg::XFER_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // --------------------
    // Bus and memory side
    // --------------------
    assign hready = (cur_state != ahb_mem_pkg::XFER_WAIT) &&
                    (cur_state != ahb_mem_pkg::XFER_ERR1);
    assign hresp  = (cur_state == ahb_mem_pkg::XFER_ERR1) ||
                    (cur_state == ahb_mem_pkg::XFER_ERR2);

    assign mem.we    = (cur_state == ahb_mem_pkg::XFER_ACCESS) && phase_write;
    assign mem.en    = mem.we || (last_wait && !phase_write);  // Read one cycle early.
    assign mem.word  = phase_word;
    assign mem.wdata = hwdata;                                 // Stable in last cycle.

    // --------------------
    // Checks
    // --------------------
    a_resp_done: assert property (@(posedge mem_intf) disable iff (!rst_n)
        (hready && hresp) |-> (state == ahb_mem_pkg::XFER_ERR2) && phase_err)
        else $error("ERROR response completes outside second error cycle");

    a_err_two: assert property (@(posedge mem_intf) disable iff (!rst_n)
        (hresp && !hready) |=> (hresp && hready))
        else $error("ERROR response not two cycles");

    a_no_err_access: assert property (@(posedge mem_intf) disable iff (!rst_n)
        mem.en |-> !phase_err)
        else $error("Memory access for out-of-range address");

endmodule

`default_nettype wire

// ==== src/mem_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_array #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                mem_intf,
    mem_port_if.mem             port,
    output ahb_mem_pkg::hdata_t hrdata
);

    ahb_mem_pkg::hdata_t mem [MEM_WORDS];   // Contents undefined until written.

    // --------------------
    // Single port
    // --------------------
    always_ff @(posedge mem_intf) begin
        if (port.en && port.we) begin
            mem[port.word] <= port.wdata;
        end
    end

    always_ff @(posedge mem_intf) begin
        if (port.en && !port.we) begin
            port.rdata <= mem[port.word];    // Held until the next read.
        end
    end

    assign hrdata = port.rdata;

endmodule

`default_nettype wire

// ==== src/ahb_mem_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ahb_mem_top #(
    parameter int MEM_WORDS  = 1024,  // Power of two.
    parameter int READ_WAIT  = 2,     // 1 to 15.
    parameter int WRITE_WAIT = 1      // 0 to 15.
) (
    input  logic                 mem_intf,
    input  logic                 rst_n,
    input  ahb_mem_pkg::haddr_t  haddr,
    input  ahb_mem_pkg::htrans_t htrans,
    input  logic                 hwrite,
    input  ahb_mem_pkg::hburst_t hburst,
    input  ahb_mem_pkg::hdata_t  hwdata,
    output ahb_mem_pkg::hdata_t  hrdata,
    output logic                 hready,
    output logic                 hresp
);

    localparam int WORD_W = $clog2(MEM_WORDS);

    logic                   phase_valid;
    logic                   phase_write;
    logic                   phase_err;
    logic [WORD_W-1:0]      phase_word;
    logic                   load;
    ahb_mem_pkg::wait_cnt_t load_val;
    logic                   done;

    mem_port_if #(.MEM_WORDS(MEM_WORDS)) mem_bus ();

    ahb_addr_phase #(.MEM_WORDS(MEM_WORDS)) u_addr (
        .mem_intf    (mem_intf),
        .rst_n       (rst_n),
        .haddr       (haddr),
        .htrans      (htrans),
        .hwrite      (hwrite),
        .hburst      (hburst),
        .hready      (hready),
        .phase_valid (phase_valid),
        .phase_write (phase_write),
        .phase_err   (phase_err),
        .phase_word  (phase_word)
    );

    xfer_ctrl #(
        .MEM_WORDS  (MEM_WORDS),
        .READ_WAIT  (READ_WAIT),
        .WRITE_WAIT (WRITE_WAIT)
    ) u_ctrl (
        .mem_intf    (mem_intf),
        .rst_n       (rst_n),
        .phase_valid (phase_valid),
        .phase_write (phase_write),
        .phase_err   (phase_err),
        .phase_word  (phase_word),
        .hwdata      (hwdata),
        .done        (done),
        .hready      (hready),
        .hresp       (hresp),
        .load        (load),
        .load_val    (load_val),
        .mem         (mem_bus.ctrl)
    );

    wait_timer u_timer (
        .mem_intf (mem_intf),
        .rst_n    (rst_n),
        .load     (load),
        .load_val (load_val),
        .done     (done)
    );

    mem_array #(.MEM_WORDS(MEM_WORDS)) u_mem (
        .mem_intf (mem_intf),
        .port     (mem_bus.mem),
        .hrdata   (hrdata)
    );

endmodule

`default_nettype wire

// ==== sim/tb_ahb_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_ahb_mem;

    localparam int MEM_WORDS  = 1024;
    localparam int READ_WAIT  = 2;
    localparam int WRITE_WAIT = 1;
    localparam int WORD_W     = $clog2(MEM_WORDS);
    localparam int CLK_HALF   = 50;

    localparam ahb_mem_pkg::hburst_t BURST_SINGLE = 3'b000;
    localparam ahb_mem_pkg::hburst_t BURST_INCR   = 3'b001;
    localparam ahb_mem_pkg::hburst_t BURST_INCR4  = 3'b011;

    typedef struct packed {
        logic                 write;
        ahb_mem_pkg::haddr_t  addr;
        ahb_mem_pkg::htrans_t trans;
        ahb_mem_pkg::hburst_t burst;
        ahb_mem_pkg::hdata_t  wdata;
        logic                 err;    // ERROR response expected.
    } xfer_t;

    logic                 mem_intf;
    logic                 rst_n;
    ahb_mem_pkg::haddr_t  haddr;
    ahb_mem_pkg::htrans_t htrans;
    logic                 hwrite;
    ahb_mem_pkg::hburst_t hburst;
    ahb_mem_pkg::hdata_t  hwdata;
    ahb_mem_pkg::hdata_t  hrdata;
    logic                 hready;
    logic                 hresp;

    xfer_t               stim_table [$];
    ahb_mem_pkg::hdata_t ref_mem [MEM_WORDS];  // Reference memory.
    int                  error_count;
    int                  check_count;
    logic                table_ready;

    ahb_mem_top dut0 (
        .mem_intf (mem_intf),
        .rst_n    (rst_n),
        .haddr    (haddr),
        .htrans   (htrans),
        .hwrite   (hwrite),
        .hburst   (hburst),
        .hwdata   (hwdata),
        .hrdata   (hrdata),
        .hready   (hready),
        .hresp    (hresp)
    );

    always #CLK_HALF mem_intf = ~mem_intf;

    // --------------------
    // Helpers
    // --------------------
    function automatic logic is_active(input ahb_mem_pkg::htrans_t trans);
        return (trans == ahb_mem_pkg::HTRANS_NONSEQ) || (trans == ahb_mem_pkg::HTRANS_SEQ);
    endfunction

    function automatic int expected_waits(input xfer_t x);
        if (!is_active(x.trans)) begin
            return 0;                                  // IDLE and BUSY.
        end
        if (x.err) begin
            return 1;                                  // First ERROR cycle.
        end
        return x.write ? WRITE_WAIT : READ_WAIT;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic add_xfer(input logic write, input ahb_mem_pkg::haddr_t addr,
                            input ahb_mem_pkg::htrans_t trans,
                            input ahb_mem_pkg::hburst_t burst,
                            input ahb_mem_pkg::hdata_t wdata);
        xfer_t x;
        x.write = write;
        x.addr  = addr;
        x.trans = trans;
        x.burst = burst;
        x.wdata = wdata;
        x.err   = is_active(trans) && (addr >= ahb_mem_pkg::haddr_t'(MEM_WORDS * 4));
        stim_table.push_back(x);
    endtask

    // --------------------
    // Stimulus table
    // --------------------
    task automatic build_table();
        int                  i;
        ahb_mem_pkg::haddr_t addr;
        // Single write then read.
        add_xfer(1'b1, 32'h40, ahb_mem_pkg::HTRANS_NONSEQ, BURST_SINGLE, 32'ha5a5_0040);
        add_xfer(1'b0, 32'h40, ahb_mem_pkg::HTRANS_NONSEQ, BURST_SINGLE, '0);
        // INCR4 write burst, then the read burst.
        for (i = 0; i < 4; i++) begin
            add_xfer(1'b1, 32'h80 + 32'(4 * i),
                     (i == 0) ? ahb_mem_pkg::HTRANS_NONSEQ : ahb_mem_pkg::HTRANS_SEQ,
                     BURST_INCR4, $urandom());
        end
        for (i = 0; i < 4; i++) begin
            add_xfer(1'b0, 32'h80 + 32'(4 * i),
                     (i == 0) ? ahb_mem_pkg::HTRANS_NONSEQ : ahb_mem_pkg::HTRANS_SEQ,
                     BURST_INCR4, '0);
        end
        // 0x1000 aliases word 0 if the range check fails.
        add_xfer(1'b1, 32'h0, ahb_mem_pkg::HTRANS_NONSEQ, BURST_SINGLE, 32'h1234_5678);
        add_xfer(1'b1, 32'h1000, ahb_mem_pkg::HTRANS_NONSEQ, BURST_SINGLE, 32'hdead_beef);
        add_xfer(1'b0, 32'h2000_0000, ahb_mem_pkg::HTRANS_NONSEQ, BURST_SINGLE, '0);
        add_xfer(1'b0, 32'h0, ahb_mem_pkg::HTRANS_NONSEQ, BURST_SINGLE, '0);
        // IDLE and BUSY carry write data that must not land.
        add_xfer(1'b1, 32'h204, ahb_mem_pkg::HTRANS_NONSEQ, BURST_SINGLE, 32'h1111_0204);
        add_xfer(1'b1, 32'h40, ahb_mem_pkg::HTRANS_IDLE, BURST_SINGLE, 32'hffff_0040);
        add_xfer(1'b1, 32'h200, ahb_mem_pkg::HTRANS_NONSEQ, BURST_INCR, 32'h2222_0200);
        add_xfer(1'b1, 32'h204, ahb_mem_pkg::HTRANS_BUSY, BURST_INCR, 32'hffff_0204);
        add_xfer(1'b0, 32'h0, ahb_mem_pkg::HTRANS_IDLE, BURST_SINGLE, '0);
        add_xfer(1'b0, 32'h40, ahb_mem_pkg::HTRANS_NONSEQ, BURST_SINGLE, '0);
        add_xfer(1'b0, 32'h204, ahb_mem_pkg::HTRANS_NONSEQ, BURST_SINGLE, '0);
        // Random traffic over eight words, all written first.
        for (i = 0; i < 8; i++) begin
            add_xfer(1'b1, 32'h300 + 32'(4 * i), ahb_mem_pkg::HTRANS_NONSEQ, BURST_SINGLE,
                     $urandom());
        end
        for (i = 0; i < 24; i++) begin
            addr = 32'h300 + 32'(4 * ($urandom() % 8));
            add_xfer(1'($urandom() % 2), addr, ahb_mem_pkg::HTRANS_NONSEQ, BURST_SINGLE,
                     $urandom());
        end
    endtask

    // --------------------
    // Master driver
    // --------------------
    task automatic drive_addr(input int idx);
        if (idx < 0) begin
            haddr  = '0;
            htrans = ahb_mem_pkg::HTRANS_IDLE;
            hwrite = 1'b0;
            hburst = BURST_SINGLE;
        end else begin
            haddr  = stim_table[idx].addr;
            htrans = stim_table[idx].trans;
            hwrite = stim_table[idx].write;
            hburst = stim_table[idx].burst;
        end
    endtask

    task automatic complete_phase(input int idx, input int waits);
        xfer_t             x;
        logic [WORD_W-1:0] word;
        x    = stim_table[idx];
        word = x.addr[WORD_W+1:2];
        check_value(32'(waits), 32'(expected_waits(x)), $sformatf("wait states, entry %0d", idx));
        check_value(32'(hresp), 32'(x.err), $sformatf("hresp, entry %0d", idx));
        if (is_active(x.trans) && !x.err) begin
            if (x.write) begin
                ref_mem[word] = x.wdata;
            end else begin
                check_value(hrdata, ref_mem[word], $sformatf("read data at %h", x.addr));
            end
        end
    endtask

    // Address phase of the next entry overlaps the data phase of the current one.
    task automatic run_table();
        int   n;
        int   data_idx;
        int   addr_idx;
        int   next_idx;
        int   low_cnt;
        logic advance;
        n        = stim_table.size();
        data_idx = -1;
        addr_idx = -1;
        next_idx = 0;
        low_cnt  = 0;
        advance  = 1'b1;
        while (data_idx >= 0 || addr_idx >= 0 || next_idx < n) begin
            @(negedge mem_intf);
            if (advance) begin
                data_idx = addr_idx;
                addr_idx = (next_idx < n) ? next_idx : -1;
                next_idx = next_idx + 1;
                drive_addr(addr_idx);
                hwdata   = (data_idx < 0) ? '0 : stim_table[data_idx].wdata;
                low_cnt  = 0;
            end
            if (hready === 1'b1) begin
                if (data_idx >= 0) begin
                    complete_phase(data_idx, low_cnt);
                end
                advance = 1'b1;
            end else begin
                low_cnt++;
                if (data_idx >= 0) begin
                    check_value(32'(hresp), 32'(stim_table[data_idx].err),
                                $sformatf("hresp in wait, entry %0d", data_idx));
                end
                advance = 1'b0;                        // Hold the address phase.
            end
        end
    endtask

    // --------------------
    // Run and report
    // --------------------
    initial begin
        void'($urandom(32'h6ef9));
        mem_intf    = 1'b0;
        rst_n       = 1'b0;
        haddr       = '0;
        htrans      = ahb_mem_pkg::HTRANS_IDLE;
        hwrite      = 1'b0;
        hburst      = BURST_SINGLE;
        hwdata      = '0;
        error_count = 0;
        check_count = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(negedge mem_intf);
        rst_n = 1'b1;
        run_table();
        @(negedge mem_intf);
        $display("Entries: %0d, checks: %0d, errors: %0d",
                 stim_table.size(), check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Worst case of 15 wait states plus slack per entry.
    initial begin
        longint limit_ns;
        wait (table_ready === 1'b1);
        limit_ns = longint'(stim_table.size()) * (15 + 4) * 100 + 2 * 100;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
src/ahb_mem_pkg.sv
src/mem_port_if.sv
src/ahb_addr_phase.sv
src/wait_timer.sv
src/xfer_ctrl.sv
src/mem_array.sv
src/ahb_mem_top.sv
sim/tb_ahb_mem.sv

// ==== Makefile ====
# Verilator build and run for the AHB-Lite memory slave.

VERILATOR ?= verilator
TOP       ?= tb_ahb_mem
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output.
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(BUILD_DIR)
